/* Makefile */
# Verilator lint and simulation of the pipelined core testbench

TOP := tb_cpu

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f build.f

# The run passes only if the log holds the pass line
sim:
	verilator --binary --timing --assert --top-module $(TOP) -f build.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -qx "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* alu.sv */
/* Execute-stage arithmetic, logic and shift unit. The compare flags
   serve bne and blt, with $rd on a and $rs on b */
`timescale 1ns/1ps

module alu (
    input  isa_pkg::word_t    a,
    input  isa_pkg::word_t    b,
    input  isa_pkg::alu_op_e  op,
    input  isa_pkg::reg_idx_t shamt,
    output isa_pkg::word_t    result,
    output logic              not_equal,
    output logic              less_than
);

    always_comb begin
        case (op)
            isa_pkg::alu_add: begin
                result = a + b;
            end
            isa_pkg::alu_sub: begin
                result = a - b;
            end
            isa_pkg::alu_and: begin
                result = a & b;
            end
            isa_pkg::alu_or: begin
                result = a | b;
            end
            isa_pkg::alu_sll: begin
                result = a << shamt;
            end
            isa_pkg::alu_sra: begin
                // Arithmetic shift keeps the sign bit
                result = isa_pkg::word_t'($signed(a) >>> shamt);
            end
            default: begin
                result = '0;
            end
        endcase
    end

    assign not_equal = (a != b);
    assign less_than = ($signed(a) < $signed(b));

endmodule

/* build.f */
+incdir+.
isa_pkg.sv
pipe_pkg.sv
instr_decoder.sv
alu.sv
reg_file.sv
hazard_unit.sv
cpu_core.sv
cpu_assert.sv
tb_cpu.sv

/* cpu_assert.sv */
/* Concurrent checks on the core's store enable and fetch address,
   bound into every cpu_core instance */
`timescale 1ns/1ps

module cpu_assert (
    input logic           clock,
    input logic           rst,
    input logic           wren,
    input logic           stall,
    input isa_pkg::word_t address_imem
);
    // Count of failed properties
    int failures = 0;

    // No store while in reset or in the first cycle after it
    assert property (@(posedge clock) rst |=> !wren)
        else begin
            $error("wren high during reset or in the cycle after it");
            failures++;
        end

    assert property (@(posedge clock) disable iff (rst) !$isunknown(wren))
        else begin
            $error("wren is unknown");
            failures++;
        end

    // Interlock freezes fetch
    assert property (@(posedge clock) disable iff (rst) stall |=> $stable(address_imem))
        else begin
            $error("address_imem moved during a load-use stall");
            failures++;
        end

endmodule

bind cpu_core cpu_assert u_assert (
    .clock        (clock),
    .rst          (rst),
    .wren         (wren),
    .stall        (stall),
    .address_imem (address_imem)
);

/* cpu_consts.svh */
/* Fixed widths, instruction field positions and reset values of the core.
   Included by the ISA package and by the modules that slice instruction words */
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Data path and register file
`define CPU_XLEN      32
`define CPU_REG_AW    5
`define CPU_NUM_REGS  32

// Instruction field widths
`define CPU_OP_W      5
`define CPU_ALU_OP_W  5
`define CPU_IMM_W     17
`define CPU_TARGET_W  27

// Low bit of each instruction field
`define CPU_OP_LSB     27
`define CPU_RD_LSB     22
`define CPU_RS_LSB     17
`define CPU_RT_LSB     12
`define CPU_SHAMT_LSB  7
`define CPU_ALU_LSB    2

// jal writes its return address here
`define CPU_LINK_REG  5'd31
`define CPU_RESET_PC  32'd0

`endif

/* cpu_core.sv */
/* Five-stage pipelined core with internal register file. Instruction and
   data memories sit outside and answer in the same cycle */
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_core (
    input  logic           clock,
    input  logic           rst,
    output isa_pkg::word_t address_imem,
    input  isa_pkg::word_t instr,
    output isa_pkg::word_t address_dmem,
    output isa_pkg::word_t data,
    output logic           wren,
    input  isa_pkg::word_t q_dmem
);
    isa_pkg::word_t     pc;
    pipe_pkg::fd_t      fd;
    pipe_pkg::dx_t      dx;
    pipe_pkg::xm_t      xm;
    pipe_pkg::mw_t      mw;
    isa_pkg::ctrl_t     d_ctrl;
    isa_pkg::word_t     rd_data_a;
    isa_pkg::word_t     rd_data_b;
    logic               stall;
    logic               store_fwd;
    pipe_pkg::byp_sel_e sel_a;
    pipe_pkg::byp_sel_e sel_b;
    isa_pkg::word_t     op_a;
    isa_pkg::word_t     op_b;
    isa_pkg::word_t     alu_b;
    isa_pkg::word_t     alu_result;
    logic               not_equal;
    logic               less_than;
    isa_pkg::word_t     link_pc;
    isa_pkg::word_t     branch_pc;
    logic               taken;
    logic               redirect;
    isa_pkg::word_t     redirect_pc;
    isa_pkg::word_t     wb_data;

    function automatic isa_pkg::word_t bypass(
        input pipe_pkg::byp_sel_e sel,
        input isa_pkg::word_t     reg_val,
        input isa_pkg::word_t     mem_val,
        input isa_pkg::word_t     wb_val
    );
        case (sel)
            pipe_pkg::from_mem: return mem_val;
            pipe_pkg::from_wb:  return wb_val;
            default:            return reg_val;
        endcase
    endfunction

    // Fetch
    always_ff @(posedge clock) begin
        if (rst) begin
            pc <= `CPU_RESET_PC;
        end else if (redirect) begin
            pc <= redirect_pc;
        end else if (!stall) begin
            pc <= pc + 32'd1;
        end
    end

    assign address_imem = pc;

    // Squashed slots become the all-zero word, an add into r0
    always_ff @(posedge clock) begin
        if (rst || redirect) begin
            fd <= '0;
        end else if (!stall) begin
            fd.pc    <= pc;
            fd.instr <= instr;
        end
    end

    // Decode
    instr_decoder dec_d (
        .instr (fd.instr),
        .ctrl  (d_ctrl)
    );

    reg_file u_reg_file (
        .clock     (clock),
        .rst       (rst),
        .rd_idx_a  (d_ctrl.src_a),
        .rd_idx_b  (d_ctrl.src_b),
        .wr_idx    (mw.ctrl.rd),
        .wr_en     (mw.ctrl.reg_write),
        .wr_data   (wb_data),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b)
    );

    hazard_unit u_hazard (
        .d_ctrl    (d_ctrl),
        .x_ctrl    (dx.ctrl),
        .m_ctrl    (xm.ctrl),
        .w_ctrl    (mw.ctrl),
        .stall     (stall),
        .sel_a     (sel_a),
        .sel_b     (sel_b),
        .store_fwd (store_fwd)
    );

    // Bubble into execute on interlock or redirect
    always_ff @(posedge clock) begin
        if (rst || redirect || stall) begin
            dx.ctrl <= '0;
        end else begin
            dx.ctrl <= d_ctrl;
        end
        dx.pc   <= fd.pc;
        dx.op_a <= rd_data_a;
        dx.op_b <= rd_data_b;
    end

    // Execute
    assign op_a  = bypass(sel_a, dx.op_a, xm.result, wb_data);
    assign op_b  = bypass(sel_b, dx.op_b, xm.result, wb_data);
    assign alu_b = dx.ctrl.use_imm ? dx.ctrl.imm : op_b;

    alu u_alu (
        .a         (op_a),
        .b         (alu_b),
        .op        (dx.ctrl.alu_op),
        .shamt     (dx.ctrl.shamt),
        .result    (alu_result),
        .not_equal (not_equal),
        .less_than (less_than)
    );

    assign link_pc   = dx.pc + 32'd1;
    assign branch_pc = link_pc + dx.ctrl.imm;
    assign taken     = dx.ctrl.is_branch &&
                       ((dx.ctrl.opcode == isa_pkg::op_blt) ? less_than : not_equal);
    assign redirect  = taken || dx.ctrl.is_jump || dx.ctrl.is_jr;

    assign redirect_pc = dx.ctrl.is_jr   ? op_a :
                         dx.ctrl.is_jump ? isa_pkg::word_t'(dx.ctrl.target) :
                                           branch_pc;

    always_ff @(posedge clock) begin
        if (rst) begin
            xm.ctrl <= '0;
        end else begin
            xm.ctrl <= dx.ctrl;
        end
        xm.result     <= dx.ctrl.is_link ? link_pc : alu_result;
        xm.store_data <= op_b;
    end

    // Memory
    assign address_dmem = xm.result;
    assign wren         = xm.ctrl.mem_write;
    assign data         = store_fwd ? wb_data : xm.store_data;

    always_ff @(posedge clock) begin
        if (rst) begin
            mw.ctrl <= '0;
        end else begin
            mw.ctrl <= xm.ctrl;
        end
        mw.result    <= xm.result;
        mw.load_data <= q_dmem;
    end

    // Writeback
    assign wb_data = mw.ctrl.mem_read ? mw.load_data : mw.result;

endmodule

/* hazard_unit.sv */
/* Load-use interlock and bypass selection for the execute operands.
   Also flags a store whose data must come from the load just ahead of it */
`timescale 1ns/1ps

module hazard_unit (
    input  isa_pkg::ctrl_t     d_ctrl,
    input  isa_pkg::ctrl_t     x_ctrl,
    input  isa_pkg::ctrl_t     m_ctrl,
    input  isa_pkg::ctrl_t     w_ctrl,
    output logic               stall,
    output pipe_pkg::byp_sel_e sel_a,
    output pipe_pkg::byp_sel_e sel_b,
    output logic               store_fwd
);
    logic load_use_a;
    logic load_use_b;

    // True when an older stage writes the register a source reads
    function automatic logic hits(
        input isa_pkg::reg_idx_t src,
        input logic              used,
        input isa_pkg::ctrl_t    prod
    );
        return used && prod.reg_write && (prod.rd != '0) && (prod.rd == src);
    endfunction

    // Memory stage holds the younger value, so it wins over writeback
    assign sel_a = hits(x_ctrl.src_a, x_ctrl.reads_a, m_ctrl) ? pipe_pkg::from_mem :
                   hits(x_ctrl.src_a, x_ctrl.reads_a, w_ctrl) ? pipe_pkg::from_wb  :
                                                                 pipe_pkg::from_reg;
    assign sel_b = hits(x_ctrl.src_b, x_ctrl.reads_b, m_ctrl) ? pipe_pkg::from_mem :
                   hits(x_ctrl.src_b, x_ctrl.reads_b, w_ctrl) ? pipe_pkg::from_wb  :
                                                                 pipe_pkg::from_reg;

    // Load in execute feeding decode
    assign load_use_a = hits(d_ctrl.src_a, d_ctrl.reads_a, x_ctrl);

    // Store data is patched in memory instead, so only non-store B reads stall
    assign load_use_b = hits(d_ctrl.src_b, d_ctrl.reads_b && !d_ctrl.mem_write, x_ctrl);

    assign stall = x_ctrl.mem_read && (load_use_a || load_use_b);

    assign store_fwd = m_ctrl.mem_write && w_ctrl.mem_read &&
                       hits(m_ctrl.src_b, m_ctrl.reads_b, w_ctrl);

endmodule

/* instr_decoder.sv */
/* Combinational decode of one instruction word into the control struct.
   Unknown opcodes and ALU operations come out as a nop */
`timescale 1ns/1ps
`include "cpu_consts.svh"

module instr_decoder (
    input  isa_pkg::word_t instr,
    output isa_pkg::ctrl_t ctrl
);
    logic [`CPU_OP_W-1:0]     op_raw;
    logic [`CPU_ALU_OP_W-1:0] alu_raw;
    isa_pkg::reg_idx_t        f_rd;
    isa_pkg::reg_idx_t        f_rs;
    isa_pkg::reg_idx_t        f_rt;
    isa_pkg::imm_t            imm_raw;

    assign op_raw  = instr[`CPU_OP_LSB +: `CPU_OP_W];
    assign alu_raw = instr[`CPU_ALU_LSB +: `CPU_ALU_OP_W];
    assign f_rd    = instr[`CPU_RD_LSB +: `CPU_REG_AW];
    assign f_rs    = instr[`CPU_RS_LSB +: `CPU_REG_AW];
    assign f_rt    = instr[`CPU_RT_LSB +: `CPU_REG_AW];
    assign imm_raw = instr[`CPU_IMM_W-1:0];

    always_comb begin
        ctrl        = '0;
        ctrl.opcode = isa_pkg::opcode_e'(op_raw);
        ctrl.alu_op = isa_pkg::alu_add;
        ctrl.shamt  = instr[`CPU_SHAMT_LSB +: `CPU_REG_AW];
        ctrl.imm    = {{(`CPU_XLEN-`CPU_IMM_W){imm_raw[`CPU_IMM_W-1]}}, imm_raw};
        ctrl.target = instr[`CPU_TARGET_W-1:0];
        case (op_raw)
            isa_pkg::op_alu: begin
                if (alu_raw <= isa_pkg::alu_sra) begin
                    ctrl.alu_op    = isa_pkg::alu_op_e'(alu_raw);
                    ctrl.rd        = f_rd;
                    ctrl.src_a     = f_rs;
                    ctrl.src_b     = f_rt;
                    ctrl.reg_write = 1'b1;
                    ctrl.reads_a   = 1'b1;
                    // Shifts take shamt instead of rt
                    ctrl.reads_b   = (alu_raw != isa_pkg::alu_sll) &&
                                     (alu_raw != isa_pkg::alu_sra);
                end
            end
            isa_pkg::op_addi, isa_pkg::op_lw: begin
                ctrl.rd        = f_rd;
                ctrl.src_a     = f_rs;
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.reads_a   = 1'b1;
                ctrl.mem_read  = (op_raw == isa_pkg::op_lw);
            end
            isa_pkg::op_sw: begin
                // Address from rs, data from rd
                ctrl.src_a     = f_rs;
                ctrl.src_b     = f_rd;
                ctrl.use_imm   = 1'b1;
                ctrl.mem_write = 1'b1;
                ctrl.reads_a   = 1'b1;
                ctrl.reads_b   = 1'b1;
            end
            isa_pkg::op_bne, isa_pkg::op_blt: begin
                ctrl.src_a     = f_rd;
                ctrl.src_b     = f_rs;
                ctrl.is_branch = 1'b1;
                ctrl.reads_a   = 1'b1;
                ctrl.reads_b   = 1'b1;
            end
            isa_pkg::op_j: begin
                ctrl.is_jump = 1'b1;
            end
            isa_pkg::op_jal: begin
                ctrl.rd        = `CPU_LINK_REG;
                ctrl.is_jump   = 1'b1;
                ctrl.is_link   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            isa_pkg::op_jr: begin
                ctrl.src_a   = f_rd;
                ctrl.is_jr   = 1'b1;
                ctrl.reads_a = 1'b1;
            end
            default: begin
                ctrl.opcode = isa_pkg::op_alu;
            end
        endcase
    end

endmodule

/* isa_pkg.sv */
/* Instruction set types: field widths, opcodes, ALU operations and the
   decoded control word that travels down the pipeline */
`include "cpu_consts.svh"

package isa_pkg;

    typedef logic [`CPU_XLEN-1:0]     word_t;
    typedef logic [`CPU_REG_AW-1:0]   reg_idx_t;
    typedef logic [`CPU_IMM_W-1:0]    imm_t;
    typedef logic [`CPU_TARGET_W-1:0] target_t;

    // Opcodes not listed here decode as nop
    typedef enum logic [`CPU_OP_W-1:0] {
        op_alu  = 5'd0,
        op_j    = 5'd1,
        op_bne  = 5'd2,
        op_jal  = 5'd3,
        op_jr   = 5'd4,
        op_addi = 5'd5,
        op_blt  = 5'd6,
        op_sw   = 5'd7,
        op_lw   = 5'd8
    } opcode_e;

    typedef enum logic [`CPU_ALU_OP_W-1:0] {
        alu_add = 5'd0,
        alu_sub = 5'd1,
        alu_and = 5'd2,
        alu_or  = 5'd3,
        alu_sll = 5'd4,
        alu_sra = 5'd5
    } alu_op_e;

    typedef struct packed {
        opcode_e  opcode;
        alu_op_e  alu_op;
        reg_idx_t rd;
        reg_idx_t src_a;
        reg_idx_t src_b;
        reg_idx_t shamt;
        word_t    imm;
        target_t  target;
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
        logic     use_imm;
        logic     is_branch;
        logic     is_jump;
        logic     is_jr;
        logic     is_link;
        logic     reads_a;
        logic     reads_b;
    } ctrl_t;

endpackage

/* pipe_pkg.sv */
/* Pipeline register layouts between the five stages and the operand
   bypass selector used in execute */
package pipe_pkg;

    typedef struct packed {
        isa_pkg::word_t pc;
        isa_pkg::word_t instr;
    } fd_t;

    typedef struct packed {
        isa_pkg::word_t pc;
        isa_pkg::ctrl_t ctrl;
        isa_pkg::word_t op_a;
        isa_pkg::word_t op_b;
    } dx_t;

    // result is the ALU output, or pc+1 for jal
    typedef struct packed {
        isa_pkg::ctrl_t ctrl;
        isa_pkg::word_t result;
        isa_pkg::word_t store_data;
    } xm_t;

    typedef struct packed {
        isa_pkg::ctrl_t ctrl;
        isa_pkg::word_t result;
        isa_pkg::word_t load_data;
    } mw_t;

    typedef enum logic [1:0] {
        from_reg = 2'd0,
        from_mem = 2'd1,
        from_wb  = 2'd2
    } byp_sel_e;

endpackage

/* reg_file.sv */
/* 32-entry register file, two read ports and one write port.
   A same-cycle write is forwarded to the readers and r0 reads as zero */
`timescale 1ns/1ps
`include "cpu_consts.svh"

module reg_file (
    input  logic              clock,
    input  logic              rst,
    input  isa_pkg::reg_idx_t rd_idx_a,
    input  isa_pkg::reg_idx_t rd_idx_b,
    input  isa_pkg::reg_idx_t wr_idx,
    input  logic              wr_en,
    input  isa_pkg::word_t    wr_data,
    output isa_pkg::word_t    rd_data_a,
    output isa_pkg::word_t    rd_data_b
);
    isa_pkg::word_t regs [`CPU_NUM_REGS];
    logic           wr_live;

    // r0 is never written, so it stays at its reset value
    assign wr_live = wr_en && (wr_idx != '0);

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < `CPU_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[wr_idx] <= wr_data;
        end
    end

    assign rd_data_a = (wr_live && wr_idx == rd_idx_a) ? wr_data : regs[rd_idx_a];
    assign rd_data_b = (wr_live && wr_idx == rd_idx_b) ? wr_data : regs[rd_idx_b];

endmodule

/* tb_cpu.sv */
/* Testbench for the pipelined core. Models both memories, runs directed
   programs and compares every data memory write with the expected list */
`timescale 1ns/1ps
`include "cpu_consts.svh"

module tb_cpu;
    localparam int num_tests   = 5;
    localparam int max_prog    = 64;
    localparam int test_cycles = max_prog + 30;

    logic           clock;
    logic           rst;
    isa_pkg::word_t address_imem;
    isa_pkg::word_t instr;
    isa_pkg::word_t address_dmem;
    isa_pkg::word_t data;
    logic           wren;
    isa_pkg::word_t q_dmem;

    isa_pkg::word_t imem [256];
    isa_pkg::word_t dmem [256];
    isa_pkg::word_t prog [$];
    isa_pkg::word_t log_addr [$];
    isa_pkg::word_t log_data [$];
    isa_pkg::word_t exp_addr [$];
    isa_pkg::word_t exp_data [$];

    integer seed = 32'h7250;
    int     errors;
    int     err_base;
    int     tests_passed;
    int     tests_failed;

    cpu_core dut (
        .clock        (clock),
        .rst          (rst),
        .address_imem (address_imem),
        .instr        (instr),
        .address_dmem (address_dmem),
        .data         (data),
        .wren         (wren),
        .q_dmem       (q_dmem)
    );

    always #50 clock = ~clock;

    assign instr  = imem[address_imem[7:0]];
    assign q_dmem = dmem[address_dmem[7:0]];

    // Data memory write port, every write logged in order
    always @(posedge clock) begin
        if (wren === 1'b1) begin
            dmem[address_dmem[7:0]] <= data;
            log_addr.push_back(address_dmem);
            log_data.push_back(data);
        end
    end

    function automatic isa_pkg::word_t fill_word(input isa_pkg::word_t addr);
        return (addr * 32'h9e37_79b9) ^ 32'h5a5a_c3c3;
    endfunction

    function automatic isa_pkg::word_t sext_imm(input isa_pkg::imm_t imm);
        return {{15{imm[16]}}, imm};
    endfunction

    // Reference results straight from the ISA rules
    function automatic isa_pkg::word_t alu_model(input isa_pkg::alu_op_e op,
            input isa_pkg::word_t a, input isa_pkg::word_t b, input isa_pkg::reg_idx_t sh);
        case (op)
            isa_pkg::alu_add: return a + b;
            isa_pkg::alu_sub: return a - b;
            isa_pkg::alu_and: return a & b;
            isa_pkg::alu_or:  return a | b;
            isa_pkg::alu_sll: return a << sh;
            isa_pkg::alu_sra: return isa_pkg::word_t'({{32{a[31]}}, a} >> sh);
            default:          return 32'd0;
        endcase
    endfunction

    function automatic isa_pkg::word_t r_type(input isa_pkg::alu_op_e op,
            input isa_pkg::reg_idx_t rd, input isa_pkg::reg_idx_t rs,
            input isa_pkg::reg_idx_t rt, input isa_pkg::reg_idx_t sh);
        return {isa_pkg::op_alu, rd, rs, rt, sh, op, 2'b00};
    endfunction

    function automatic isa_pkg::word_t i_type(input isa_pkg::opcode_e op,
            input isa_pkg::reg_idx_t rd, input isa_pkg::reg_idx_t rs, input isa_pkg::imm_t imm);
        return {op, rd, rs, imm};
    endfunction

    function automatic isa_pkg::word_t j_type(input isa_pkg::opcode_e op,
            input isa_pkg::target_t target);
        return {op, target};
    endfunction

    // Builds the full word from a 17-bit upper part, a shift and a 15-bit lower part
    task automatic put_const(input isa_pkg::reg_idx_t rd, input isa_pkg::word_t v);
        prog.push_back(i_type(isa_pkg::op_addi, rd, 5'd0, v[31:15]));
        prog.push_back(r_type(isa_pkg::alu_sll, rd, rd, 5'd0, 5'd15));
        prog.push_back(i_type(isa_pkg::op_addi, rd, rd, {2'b00, v[14:0]}));
    endtask

    task automatic store_expect(input isa_pkg::reg_idx_t rd, input isa_pkg::reg_idx_t rs,
            input isa_pkg::imm_t imm, input isa_pkg::word_t base, input isa_pkg::word_t v);
        prog.push_back(i_type(isa_pkg::op_sw, rd, rs, imm));
        exp_addr.push_back(base + sext_imm(imm));
        exp_data.push_back(v);
    endtask

    task automatic alu_step(input isa_pkg::alu_op_e op, input isa_pkg::reg_idx_t rd,
            input isa_pkg::reg_idx_t rs, input isa_pkg::reg_idx_t rt,
            input isa_pkg::reg_idx_t sh, input isa_pkg::word_t a, input isa_pkg::word_t b,
            input isa_pkg::imm_t addr, output isa_pkg::word_t r);
        r = alu_model(op, a, b, sh);
        prog.push_back(r_type(op, rd, rs, rt, sh));
        store_expect(rd, 5'd0, addr, 32'd0, r);
    endtask

    task automatic jump_self();
        prog.push_back(j_type(isa_pkg::op_j, isa_pkg::target_t'(prog.size())));
    endtask

    task automatic begin_test();
        prog.delete();
        exp_addr.delete();
        exp_data.delete();
        err_base = errors;
    endtask

    // Reset, load the program while in reset, then run length plus 20 cycles
    task automatic run_program();
        int n;
        n = prog.size();
        if (n > max_prog) begin
            $display("Program of %0d words is longer than the run time allows", n);
            errors++;
        end
        @(posedge clock);
        rst <= 1'b1;
        @(posedge clock);
        for (int i = 0; i < 256; i++) begin
            imem[i] = (i < n) ? prog[i] : 32'd0;
            dmem[i] <= fill_word(isa_pkg::word_t'(i));
        end
        log_addr.delete();
        log_data.delete();
        repeat (2) @(posedge clock);
        rst <= 1'b0;
        @(negedge clock);
        if (address_imem !== `CPU_RESET_PC) begin
            $display("Fail at time %0t: address_imem is %h after reset", $time, address_imem);
            errors++;
        end
        repeat (n + 20) @(posedge clock);
    endtask

    task automatic finish_test(input string name);
        int n;
        n = (log_addr.size() < exp_addr.size()) ? log_addr.size() : exp_addr.size();
        for (int i = 0; i < n; i++) begin
            if (log_addr[i] !== exp_addr[i] || log_data[i] !== exp_data[i]) begin
                $display("Fail at time %0t: %s write %0d is %h at %0d, expected %h at %0d",
                         $time, name, i, log_data[i], log_addr[i], exp_data[i], exp_addr[i]);
                errors++;
            end
        end
        if (log_addr.size() != exp_addr.size()) begin
            $display("Test %s: the core made %0d data memory writes where %0d were expected",
                     name, log_addr.size(), exp_addr.size());
            errors++;
        end
        if (errors == err_base) begin
            $display("Test %s: ok", name);
            tests_passed++;
        end else begin
            $display("Test %s: %0d errors", name, errors - err_base);
            tests_failed++;
        end
    endtask

    task automatic test_reset();
        begin_test();
        repeat (6) prog.push_back(32'd0);
        store_expect(5'd0, 5'd0, 17'd220, 32'd0, 32'd0);
        jump_self();
        run_program();
        finish_test("reset");
    endtask

    task automatic test_alu();
        isa_pkg::word_t    va;
        isa_pkg::word_t    vb;
        isa_pkg::word_t    rv [12];
        isa_pkg::reg_idx_t sh;
        isa_pkg::imm_t     im;
        begin_test();
        va = $random(seed);
        vb = $random(seed);
        sh = isa_pkg::reg_idx_t'($random(seed));
        im = isa_pkg::imm_t'($random(seed));
        put_const(5'd1, va);
        put_const(5'd2, vb);
        // Each store takes its data from the memory stage and the next op from writeback
        alu_step(isa_pkg::alu_add, 5'd3, 5'd1, 5'd2, 5'd0, va, vb, 17'd100, rv[3]);
        alu_step(isa_pkg::alu_sub, 5'd4, 5'd3, 5'd1, 5'd0, rv[3], va, 17'd101, rv[4]);
        alu_step(isa_pkg::alu_and, 5'd5, 5'd4, 5'd2, 5'd0, rv[4], vb, 17'd102, rv[5]);
        alu_step(isa_pkg::alu_or, 5'd6, 5'd5, 5'd1, 5'd0, rv[5], va, 17'd103, rv[6]);
        alu_step(isa_pkg::alu_sll, 5'd7, 5'd6, 5'd0, sh, rv[6], 32'd0, 17'd104, rv[7]);
        alu_step(isa_pkg::alu_sra, 5'd8, 5'd1, 5'd0, sh, va, 32'd0, 17'd105, rv[8]);
        rv[9] = rv[8] + sext_imm(im);
        prog.push_back(i_type(isa_pkg::op_addi, 5'd9, 5'd8, im));
        store_expect(5'd9, 5'd0, 17'd106, 32'd0, rv[9]);
        // Back to back with no store in between
        rv[10] = rv[9] + rv[7];
        rv[11] = rv[10] - vb;
        prog.push_back(r_type(isa_pkg::alu_add, 5'd10, 5'd9, 5'd7, 5'd0));
        prog.push_back(r_type(isa_pkg::alu_sub, 5'd11, 5'd10, 5'd2, 5'd0));
        store_expect(5'd11, 5'd0, 17'd107, 32'd0, rv[11]);
        prog.push_back(i_type(isa_pkg::op_addi, 5'd0, 5'd1, 17'd5));
        store_expect(5'd0, 5'd0, 17'd108, 32'd0, 32'd0);
        jump_self();
        run_program();
        finish_test("alu");
    endtask

    task automatic test_load_store();
        isa_pkg::word_t base;
        isa_pkg::imm_t  off1;
        isa_pkg::imm_t  off2;
        isa_pkg::imm_t  off3;
        isa_pkg::imm_t  im;
        begin_test();
        base = 32'd16 + ($random(seed) & 32'd63);
        off1 = isa_pkg::imm_t'($random(seed) & 15);
        off2 = isa_pkg::imm_t'($random(seed) & 15);
        off3 = isa_pkg::imm_t'($random(seed) & 15);
        im   = isa_pkg::imm_t'($random(seed));
        put_const(5'd1, base);
        // Load-use interlock
        prog.push_back(i_type(isa_pkg::op_lw, 5'd2, 5'd1, off1));
        prog.push_back(i_type(isa_pkg::op_addi, 5'd3, 5'd2, im));
        store_expect(5'd3, 5'd0, 17'd120, 32'd0, fill_word(base + sext_imm(off1)) + sext_imm(im));
        // Store data straight from the load ahead
        prog.push_back(i_type(isa_pkg::op_lw, 5'd4, 5'd1, off2));
        store_expect(5'd4, 5'd0, 17'd121, 32'd0, fill_word(base + sext_imm(off2)));
        prog.push_back(i_type(isa_pkg::op_lw, 5'd6, 5'd1, off3));
        prog.push_back(32'd0);
        store_expect(5'd6, 5'd0, 17'd122, 32'd0, fill_word(base + sext_imm(off3)));
        store_expect(5'd4, 5'd1, 17'd40, base, fill_word(base + sext_imm(off2)));
        jump_self();
        run_program();
        finish_test("load_store");
    endtask

    // Branch over two stores to pc+3, which are also the squashed slots
    task automatic branch_case(input isa_pkg::opcode_e op, input isa_pkg::reg_idx_t ra,
            input isa_pkg::reg_idx_t rb, input logic taken, input isa_pkg::word_t mark,
            inout isa_pkg::imm_t addr);
        prog.push_back(i_type(op, ra, rb, 17'd2));
        for (int k = 0; k < 2; k++) begin
            if (taken) begin
                prog.push_back(i_type(isa_pkg::op_sw, 5'd5, 5'd0, addr));
            end else begin
                store_expect(5'd5, 5'd0, addr, 32'd0, mark);
            end
            addr = addr + 17'd1;
        end
        store_expect(5'd5, 5'd0, addr, 32'd0, mark);
        addr = addr + 17'd1;
    endtask

    task automatic test_branches();
        isa_pkg::word_t a;
        isa_pkg::word_t b;
        isa_pkg::word_t mark;
        isa_pkg::imm_t  addr;
        begin_test();
        a    = $random(seed);
        b    = a ^ 32'h8000_0000;
        mark = $random(seed);
        addr = 17'd140;
        put_const(5'd1, a);
        put_const(5'd2, b);
        put_const(5'd5, mark);
        branch_case(isa_pkg::op_bne, 5'd1, 5'd2, a != b, mark, addr);
        branch_case(isa_pkg::op_bne, 5'd1, 5'd1, 1'b0, mark, addr);
        branch_case(isa_pkg::op_blt, 5'd1, 5'd2, $signed(a) < $signed(b), mark, addr);
        branch_case(isa_pkg::op_blt, 5'd2, 5'd1, $signed(b) < $signed(a), mark, addr);
        branch_case(isa_pkg::op_blt, 5'd1, 5'd1, 1'b0, mark, addr);
        jump_self();
        run_program();
        finish_test("branches");
    endtask

    task automatic test_jumps();
        isa_pkg::word_t mark;
        isa_pkg::word_t b;
        begin_test();
        mark = $random(seed);
        put_const(5'd5, mark);
        b = isa_pkg::word_t'(prog.size());
        prog.push_back(j_type(isa_pkg::op_j, isa_pkg::target_t'(b + 32'd3)));
        prog.push_back(i_type(isa_pkg::op_sw, 5'd5, 5'd0, 17'd130));
        prog.push_back(i_type(isa_pkg::op_sw, 5'd5, 5'd0, 17'd131));
        prog.push_back(j_type(isa_pkg::op_jal, isa_pkg::target_t'(b + 32'd7)));
        prog.push_back(i_type(isa_pkg::op_sw, 5'd5, 5'd0, 17'd132));
        jump_self();
        prog.push_back(32'd0);
        // Subroutine stores its link, then returns to the slot after jal
        store_expect(`CPU_LINK_REG, 5'd0, 17'd133, 32'd0, b + 32'd4);
        prog.push_back(i_type(isa_pkg::op_jr, `CPU_LINK_REG, 5'd0, 17'd0));
        prog.push_back(i_type(isa_pkg::op_sw, 5'd5, 5'd0, 17'd134));
        prog.push_back(i_type(isa_pkg::op_sw, 5'd5, 5'd0, 17'd135));
        exp_addr.push_back(32'd132);
        exp_data.push_back(mark);
        run_program();
        finish_test("jumps");
    endtask

    initial begin
        clock        = 1'b0;
        rst          = 1'b1;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = 32'd0;
        end
        test_reset();
        test_alu();
        test_load_store();
        test_branches();
        test_jumps();
        $display("%0d tests: %0d passed, %0d failed, %0d errors, %0d assertion failures",
                 num_tests, tests_passed, tests_failed, errors, dut.u_assert.failures);
        if (errors == 0 && dut.u_assert.failures == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // Watchdog sized from the longest allowed test
    initial begin
        #(num_tests * test_cycles * 100 + 5000);
        $display("Timeout: the tests did not finish in the expected time");
        $display("Testbench failed");
        $finish;
    end

endmodule
